//--- files.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/commit_if.sv
hdl/free_reg_picker.sv
hdl/spec_rat.sv
hdl/arch_rat.sv
hdl/rename_top.sv
test/rename_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rename_tb
FILELIST = files.f

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf obj_dir

//--- test/rename_tb.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_tb import rename_pkg::*; ();

    localparam int max_cycles = 4000;

    logic  clk = 1'b0;
    logic  rst;
    logic  rename_req, rename_ack, full, flush;
    areg_t rj [`RN_WIDTH-1:0];
    areg_t rk [`RN_WIDTH-1:0];
    areg_t rd [`RN_WIDTH-1:0];
    logic  regwr [`RN_WIDTH-1:0];
    preg_t pj [`RN_WIDTH-1:0];
    preg_t pk [`RN_WIDTH-1:0];
    preg_t pd [`RN_WIDTH-1:0];
    preg_t pd_old [`RN_WIDTH-1:0];
    logic  pj_ready [`RN_WIDTH-1:0];
    logic  pk_ready [`RN_WIDTH-1:0];
    logic  wb_valid [`RN_WB_PORTS-1:0];
    preg_t wb_pd [`RN_WB_PORTS-1:0];
    logic  cm_valid [`RN_CM_PORTS-1:0];
    areg_t cm_rd [`RN_CM_PORTS-1:0];
    preg_t cm_pd [`RN_CM_PORTS-1:0];
    preg_t cm_pd_old [`RN_CM_PORTS-1:0];

    // reference model of the speculative and committed state
    preg_t  m_map [`RN_AREGS-1:0];
    preg_t  a_map [`RN_AREGS-1:0];
    pmask_t m_free, m_ready, a_free;
    preg_t  e_pj [`RN_WIDTH-1:0];
    preg_t  e_pk [`RN_WIDTH-1:0];
    preg_t  e_pd [`RN_WIDTH-1:0];
    preg_t  e_old [`RN_WIDTH-1:0];
    logic   e_pjr [`RN_WIDTH-1:0];
    logic   e_pkr [`RN_WIDTH-1:0];
    int     q_rd[$], q_pd[$], q_old[$];
    logic [31:0] seed = 32'h29b5;
    int     cycles = 0;
    logic   saw_full;

    rename_top DUT (.*);

    always #20 clk = ~clk;

    task automatic stop_fail();
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic mismatch(input string name, input int idx, input logic [31:0] got,
                            input logic [31:0] exp);
        $display("MISMATCH %s[%0d] got %h expected %h", name, idx, got, exp);
        stop_fail();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout, no progress after %0d cycles", cycles);
            stop_fail();
        end
    end

    // ==================================================
    // handshake order
    // ==================================================
    a_rise_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(rename_ack) |-> $past(rename_req))
        else begin
            $display("rename_ack rose while rename_req was low");
            stop_fail();
        end
    a_fall_req: assert property (@(posedge clk) disable iff (!rst)
        $fell(rename_ack) |-> !$past(rename_req))
        else begin
            $display("rename_ack fell while rename_req was still high");
            stop_fail();
        end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic exp_full();
        int need;
        need = 0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (regwr[i] && rd[i] != '0) need++;
        end
        return need > $countones(m_free);
    endfunction

    // lookups against the old map first, then the update in program order
    task automatic predict_group();
        pmask_t avail;
        logic   wr [`RN_WIDTH-1:0];
        avail = m_free;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            wr[i] = regwr[i] && rd[i] != '0;
            e_pd[i] = '0;
            for (int p = 0; p < `RN_PREGS; p++) begin
                if (wr[i] && avail[p] && e_pd[i] == '0) e_pd[i] = preg_t'(p);
            end
            if (wr[i]) avail[e_pd[i]] = 1'b0;
            e_pj[i] = m_map[rj[i]];
            e_pjr[i] = m_ready[e_pj[i]];
            e_pk[i] = m_map[rk[i]];
            e_pkr[i] = m_ready[e_pk[i]];
            e_old[i] = m_map[rd[i]];
            for (int k = 0; k < i; k++) begin
                if (wr[k] && rd[k] == rj[i]) begin
                    e_pj[i] = e_pd[k];
                    e_pjr[i] = 1'b0;
                end
                if (wr[k] && rd[k] == rk[i]) begin
                    e_pk[i] = e_pd[k];
                    e_pkr[i] = 1'b0;
                end
                if (wr[k] && rd[k] == rd[i]) e_old[i] = e_pd[k];
            end
        end
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (wr[i]) begin
                m_map[rd[i]] = e_pd[i];
                m_free[e_pd[i]] = 1'b0;
                m_ready[e_pd[i]] = 1'b0;
                q_rd.push_back(int'(rd[i]));
                q_pd.push_back(int'(e_pd[i]));
                q_old.push_back(int'(e_old[i]));
            end
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < `RN_WIDTH; i++) begin
            assert (pj[i] == e_pj[i]) else mismatch("pj", i, 32'(pj[i]), 32'(e_pj[i]));
            assert (pk[i] == e_pk[i]) else mismatch("pk", i, 32'(pk[i]), 32'(e_pk[i]));
            assert (pd[i] == e_pd[i]) else mismatch("pd", i, 32'(pd[i]), 32'(e_pd[i]));
            assert (pd_old[i] == e_old[i])
                else mismatch("pd_old", i, 32'(pd_old[i]), 32'(e_old[i]));
            assert (pj_ready[i] == e_pjr[i])
                else mismatch("pj_ready", i, 32'(pj_ready[i]), 32'(e_pjr[i]));
            assert (pk_ready[i] == e_pkr[i])
                else mismatch("pk_ready", i, 32'(pk_ready[i]), 32'(e_pkr[i]));
        end
    endtask

    // up to two oldest renames retire
    task automatic commit_pair();
        for (int c = 0; c < `RN_CM_PORTS; c++) begin
            cm_valid[c] = 1'b0;
            if (q_rd.size() > 0) begin
                cm_valid[c] = 1'b1;
                cm_rd[c] = areg_t'(q_rd.pop_front());
                cm_pd[c] = preg_t'(q_pd.pop_front());
                cm_pd_old[c] = preg_t'(q_old.pop_front());
                a_map[cm_rd[c]] = cm_pd[c];
                a_free[cm_pd[c]] = 1'b0;
                a_free[cm_pd_old[c]] = 1'b1;
                m_free[cm_pd_old[c]] = 1'b1;
            end
        end
        @(negedge clk);
        for (int c = 0; c < `RN_CM_PORTS; c++) cm_valid[c] = 1'b0;
    endtask

    task automatic write_back(input preg_t a, input preg_t b);
        wb_valid[0] = 1'b1;
        wb_pd[0] = a;
        wb_valid[1] = 1'b1;
        wb_pd[1] = b;
        m_ready[a] = 1'b1;
        m_ready[b] = 1'b1;
        @(negedge clk);
        wb_valid[0] = 1'b0;
        wb_valid[1] = 1'b0;
    endtask

    task automatic flush_all();
        flush = 1'b1;
        m_map = a_map;
        m_free = a_free;
        m_ready = ~a_free;
        q_rd.delete();
        q_pd.delete();
        q_old.delete();
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic set_slot(input int s, input areg_t j, input areg_t k, input areg_t d,
                            input logic w);
        rj[s] = j;
        rk[s] = k;
        rd[s] = d;
        regwr[s] = w;
    endtask

    // offer a group and follow the handshake to its end
    task automatic run_group(input logic relieve);
        rename_req = 1'b1;
        saw_full = 1'b0;
        @(negedge clk);
        while (!rename_ack) begin
            assert (full == exp_full()) else mismatch("full", 0, 32'(full), 32'(exp_full()));
            if (full) saw_full = 1'b1;
            if (full && relieve) commit_pair();
            else @(negedge clk);
        end
        predict_group();
        check_outputs();
        rename_req = 1'b0;
        @(negedge clk);
        while (rename_ack) begin
            check_outputs();
            @(negedge clk);
        end
    endtask

    task automatic random_group(input logic all_wr, input logic relieve);
        logic [31:0] r;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            r = next_rand();
            set_slot(s, areg_t'(next_rand() % 32), areg_t'(next_rand() % 32),
                     areg_t'(1 + next_rand() % 31), all_wr || s == 0 || r[0]);
        end
        run_group(relieve);
    endtask

    task automatic read_all();
        for (int b = 1; b < `RN_AREGS; b += 6) begin
            for (int s = 0; s < `RN_WIDTH; s++) begin
                set_slot(s, areg_t'((b + 2 * s) % 32), areg_t'((b + 2 * s + 1) % 32), '0, 1'b0);
            end
            run_group(1'b0);
        end
    endtask

    initial begin
        rst = 1'b0;
        rename_req = 1'b0;
        flush = 1'b0;
        for (int s = 0; s < `RN_WIDTH; s++) set_slot(s, '0, '0, '0, 1'b0);
        for (int w = 0; w < `RN_WB_PORTS; w++) begin
            wb_valid[w] = 1'b0;
            wb_pd[w] = '0;
        end
        for (int c = 0; c < `RN_CM_PORTS; c++) begin
            cm_valid[c] = 1'b0;
            cm_rd[c] = '0;
            cm_pd[c] = '0;
            cm_pd_old[c] = '0;
        end
        for (int a = 0; a < `RN_AREGS; a++) begin
            m_map[a] = preg_t'(a);
            a_map[a] = preg_t'(a);
        end
        for (int p = 0; p < `RN_PREGS; p++) begin
            m_free[p] = (p >= `RN_AREGS);
            m_ready[p] = (p < `RN_AREGS);
            a_free[p] = (p >= `RN_AREGS);
        end
        repeat (10) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        // identity map after reset
        read_all();

        // in-group forwarding and an r0 destination
        set_slot(0, 5'd3, 5'd4, 5'd5, 1'b1);
        set_slot(1, 5'd5, 5'd5, 5'd5, 1'b1);
        set_slot(2, 5'd5, 5'd0, 5'd0, 1'b1);
        run_group(1'b0);

        // random renames, then a write-back and a read back
        repeat (6) random_group(1'b0, 1'b0);
        write_back(preg_t'(q_pd[q_pd.size()-1]), preg_t'(q_pd[q_pd.size()-2]));
        set_slot(0, areg_t'(q_rd[q_rd.size()-1]), areg_t'(q_rd[q_rd.size()-2]), '0, 1'b0);
        set_slot(1, '0, '0, '0, 1'b0);
        set_slot(2, '0, '0, '0, 1'b0);
        run_group(1'b0);
        while (q_rd.size() > 0) commit_pair();

        // run the free list dry, then relieve with commits
        while ($countones(m_free) >= `RN_WIDTH) random_group(1'b1, 1'b0);
        random_group(1'b1, 1'b1);
        if (!saw_full) begin
            $display("full never rose with the free registers used up");
            stop_fail();
        end

        // flush back to the committed map
        commit_pair();
        repeat (2) random_group(1'b0, 1'b0);
        flush_all();
        read_all();
        random_group(1'b1, 1'b0);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- hdl/rename_top.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_top import rename_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  rename_req,
    input  areg_t rj        [`RN_WIDTH-1:0],
    input  areg_t rk        [`RN_WIDTH-1:0],
    input  areg_t rd        [`RN_WIDTH-1:0],
    input  logic  regwr     [`RN_WIDTH-1:0],
    output logic  rename_ack,
    output preg_t pj        [`RN_WIDTH-1:0],
    output logic  pj_ready  [`RN_WIDTH-1:0],
    output preg_t pk        [`RN_WIDTH-1:0],
    output logic  pk_ready  [`RN_WIDTH-1:0],
    output preg_t pd        [`RN_WIDTH-1:0],
    output preg_t pd_old    [`RN_WIDTH-1:0],
    output logic  full,

    input  logic  wb_valid  [`RN_WB_PORTS-1:0],
    input  preg_t wb_pd     [`RN_WB_PORTS-1:0],
    input  logic  cm_valid  [`RN_CM_PORTS-1:0],
    input  areg_t cm_rd     [`RN_CM_PORTS-1:0],
    input  preg_t cm_pd     [`RN_CM_PORTS-1:0],
    input  preg_t cm_pd_old [`RN_CM_PORTS-1:0],
    input  logic  flush
);

    rn_state_t state;
    logic      accept;
    logic      wr_req    [`RN_WIDTH-1:0];
    preg_t     rat_pj    [`RN_WIDTH-1:0];
    logic      rat_pj_rdy[`RN_WIDTH-1:0];
    preg_t     rat_pk    [`RN_WIDTH-1:0];
    logic      rat_pk_rdy[`RN_WIDTH-1:0];
    preg_t     rat_pd    [`RN_WIDTH-1:0];
    preg_t     rat_pd_old[`RN_WIDTH-1:0];
    preg_t     arch_map  [`RN_AREGS-1:0];
    pmask_t    arch_free;

    commit_if cm_bus ();

    assign cm_bus.valid  = cm_valid;
    assign cm_bus.rd     = cm_rd;
    assign cm_bus.pd     = cm_pd;
    assign cm_bus.pd_old = cm_pd_old;

    // destinations only count toward full while a group is offered
    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            wr_req[i] = rename_req && regwr[i];
        end
    end

    assign accept     = rename_req && (state == rn_idle) && !full && !flush;
    assign rename_ack = (state != rn_idle);

    // ================================================
    // four-phase handshake
    // ================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= rn_idle;
        end else begin
            case (state)
                rn_idle:      if (accept) state <= rn_ack;
                rn_ack:       if (!rename_req) state <= rn_wait_drop;
                rn_wait_drop: state <= rn_idle;
                default:      state <= rn_idle;
            endcase
        end
    end

    // results held for the whole ack window
    always_ff @(posedge clk) begin
        if (accept) begin
            pj       <= rat_pj;
            pj_ready <= rat_pj_rdy;
            pk       <= rat_pk;
            pk_ready <= rat_pk_rdy;
            pd       <= rat_pd;
            pd_old   <= rat_pd_old;
        end
    end

    spec_rat u_spec (
        .*,
        .regwr    (wr_req),
        .pj       (rat_pj),
        .pj_ready (rat_pj_rdy),
        .pk       (rat_pk),
        .pk_ready (rat_pk_rdy),
        .pd       (rat_pd),
        .pd_old   (rat_pd_old),
        .cm       (cm_bus)
    );

    arch_rat u_arch (
        .*,
        .cm (cm_bus)
    );

    a_req_held: assert property (
        @(posedge clk) disable iff (!rst)
        $fell(rename_req) |-> rename_ack
    ) else $error("rename_req dropped before rename_ack");

endmodule

//--- hdl/arch_rat.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module arch_rat import rename_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    commit_if.sink cm,
    output preg_t  arch_map [`RN_AREGS-1:0],
    output pmask_t arch_free
);

    // ================================================
    // committed map, restored into spec_rat on flush
    // ================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int a = 0; a < `RN_AREGS; a++) begin
                arch_map[a] <= preg_t'(a);
            end
            for (int p = 0; p < `RN_PREGS; p++) begin
                arch_free[p] <= (p >= `RN_AREGS);
            end
        end else begin
            // port order matters, the younger commit lands last
            for (int c = 0; c < `RN_CM_PORTS; c++) begin
                if (cm.valid[c]) begin
                    arch_map[cm.rd[c]]  <= cm.pd[c];
                    arch_free[cm.pd[c]] <= 1'b0;
                    if (cm.pd_old[c] != '0) begin
                        arch_free[cm.pd_old[c]] <= 1'b1;
                    end
                end
            end
        end
    end

    for (genvar g = 0; g < `RN_CM_PORTS; g++) begin : g_cm_chk
        a_no_r0_commit: assert property (
            @(posedge clk) disable iff (!rst)
            cm.valid[g] |-> cm.rd[g] != '0
        ) else $error("commit port %0d targets r0", g);
    end

endmodule

//--- hdl/spec_rat.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module spec_rat import rename_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          accept,

    input  areg_t         rj       [`RN_WIDTH-1:0],
    input  areg_t         rk       [`RN_WIDTH-1:0],
    input  areg_t         rd       [`RN_WIDTH-1:0],
    input  logic          regwr    [`RN_WIDTH-1:0],
    output preg_t         pj       [`RN_WIDTH-1:0],
    output logic          pj_ready [`RN_WIDTH-1:0],
    output preg_t         pk       [`RN_WIDTH-1:0],
    output logic          pk_ready [`RN_WIDTH-1:0],
    output preg_t         pd       [`RN_WIDTH-1:0],
    output preg_t         pd_old   [`RN_WIDTH-1:0],
    output logic          full,

    input  logic          wb_valid [`RN_WB_PORTS-1:0],
    input  preg_t         wb_pd    [`RN_WB_PORTS-1:0],
    commit_if.sink        cm,

    input  logic          flush,
    input  preg_t         arch_map [`RN_AREGS-1:0],
    input  pmask_t        arch_free
);

    preg_t  map [`RN_AREGS-1:0];
    pmask_t ready;
    pmask_t free;

    // slots that really rename, r0 never does
    logic   wr  [`RN_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            wr[i] = regwr[i] && (rd[i] != '0);
        end
    end

    free_reg_picker u_picker (
        .free  (free),
        .regwr (wr),
        .pd    (pd),
        .short (full)
    );

    // ================================================
    // source lookup with in-group forwarding
    // ================================================
    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            pj[i]       = map[rj[i]];
            pj_ready[i] = ready[map[rj[i]]];
            pk[i]       = map[rk[i]];
            pk_ready[i] = ready[map[rk[i]]];
            pd_old[i]   = map[rd[i]];
            // walking oldest to youngest leaves the nearest older writer
            for (int k = 0; k < `RN_WIDTH; k++) begin
                if (k < i && wr[k] && rd[k] == rj[i]) begin
                    pj[i]       = pd[k];
                    pj_ready[i] = 1'b0;
                end
                if (k < i && wr[k] && rd[k] == rk[i]) begin
                    pk[i]       = pd[k];
                    pk_ready[i] = 1'b0;
                end
                if (k < i && wr[k] && rd[k] == rd[i]) begin
                    pd_old[i] = pd[k];
                end
            end
        end
    end

    // ================================================
    // map and bitmap updates
    // ================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int a = 0; a < `RN_AREGS; a++) begin
                map[a] <= preg_t'(a);
            end
            for (int p = 0; p < `RN_PREGS; p++) begin
                ready[p] <= (p < `RN_AREGS);
                free[p]  <= (p >= `RN_AREGS);
            end
        end else if (flush) begin
            map   <= arch_map;
            ready <= ~arch_free;
            free  <= arch_free;
        end else begin
            if (accept) begin
                // a younger slot overwrites the map entry of an older one
                for (int i = 0; i < `RN_WIDTH; i++) begin
                    if (wr[i]) begin
                        map[rd[i]]   <= pd[i];
                        free[pd[i]]  <= 1'b0;
                        ready[pd[i]] <= 1'b0;
                    end
                end
            end
            for (int w = 0; w < `RN_WB_PORTS; w++) begin
                if (wb_valid[w]) begin
                    ready[wb_pd[w]] <= 1'b1;
                end
            end
            for (int c = 0; c < `RN_CM_PORTS; c++) begin
                if (cm.valid[c] && cm.pd_old[c] != '0) begin
                    free[cm.pd_old[c]] <= 1'b1;
                end
            end
        end
    end

    for (genvar g = 0; g < `RN_WIDTH; g++) begin : g_alloc_chk
        a_alloc_free: assert property (
            @(posedge clk) disable iff (!rst)
            accept && wr[g] |-> free[pd[g]]
        ) else $error("slot %0d allocated busy register %0d", g, pd[g]);
    end

endmodule

//--- hdl/free_reg_picker.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_reg_picker import rename_pkg::*; (
    input  pmask_t free,
    input  logic   regwr [`RN_WIDTH-1:0],
    output preg_t  pd    [`RN_WIDTH-1:0],
    output logic   short
);

    // ================================================
    // ascending pick, one register per writing slot
    // ================================================
    always_comb begin
        pmask_t avail;
        logic   found;

        avail = free;
        short = 1'b0;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            pd[s] = '0;
            found = 1'b0;
            if (regwr[s]) begin
                // lowest index not already taken by an older slot
                for (int p = 0; p < `RN_PREGS; p++) begin
                    if (!found && avail[p]) begin
                        pd[s] = preg_t'(p);
                        found = 1'b1;
                    end
                end
                if (found) begin
                    avail[pd[s]] = 1'b0;
                end else begin
                    short = 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/commit_if.sv
`timescale 1ns/1ps
`include "rename_defs.svh"

interface commit_if import rename_pkg::*; ();

    // one entry per commit port, port 0 is the oldest
    logic  valid  [`RN_CM_PORTS-1:0];
    areg_t rd     [`RN_CM_PORTS-1:0];
    preg_t pd     [`RN_CM_PORTS-1:0];
    preg_t pd_old [`RN_CM_PORTS-1:0];

    modport source (
        output valid,
        output rd,
        output pd,
        output pd_old
    );

    // arch_rat and spec_rat both listen
    modport sink (
        input  valid,
        input  rd,
        input  pd,
        input  pd_old
    );

endinterface

//--- hdl/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

    // architectural register index
    typedef logic [`RN_AREG_BITS-1:0] areg_t;

    // physical register index
    typedef logic [`RN_PREG_BITS-1:0] preg_t;

    // one bit per physical register
    typedef logic [`RN_PREGS-1:0] pmask_t;

    // front end handshake
    // rn_ack holds the results until the request drops,
    // rn_wait_drop keeps ack up for one more cycle
    typedef enum logic [1:0] {
        rn_idle,
        rn_ack,
        rn_wait_drop
    } rn_state_t;

endpackage

//--- hdl/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// ================================================
// rename group and port counts
// ================================================
`define RN_WIDTH        3
`define RN_WB_PORTS     2
`define RN_CM_PORTS     2

// ================================================
// register file sizes
// ================================================
`define RN_AREGS        32
`define RN_PREGS        64

// index widths, tied to the register counts above
`define RN_AREG_BITS    5
`define RN_PREG_BITS    6

`endif
